// ==== exec_core_golden.txt ====
# columns in hex: inst pc rd wen wdata next_pc mem_addr
# rd and wdata matter when wen is 1, mem_addr only for loads and stores
00500093 00000100 01 1 00000005 00000104 00000000
ffd00113 00000104 02 1 fffffffd 00000108 00000000
002081b3 00000108 03 1 00000002 0000010c 00000000
40208233 0000010c 04 1 00000008 00000110 00000000
401152b3 00000110 05 1 ffffffff 00000114 00000000
001123b3 00000114 07 1 00000001 00000118 00000000
00113433 00000118 08 1 00000000 0000011c 00000000
123454b7 0000011c 09 1 12345000 00000120 00000000
00001517 00000120 0a 1 00001120 00000124 00000000
00708013 00000124 00 1 0000000c 00000128 00000000
001005b3 00000128 0b 1 00000005 0000012c 00000000
fe108ce3 0000012c 00 0 00000000 00000124 00000000
00208863 00000130 00 0 00000000 00000134 00000000
00209863 00000134 00 0 00000000 00000144 00000000
00109863 00000138 00 0 00000000 0000013c 00000000
00114863 0000013c 00 0 00000000 0000014c 00000000
0020c863 00000140 00 0 00000000 00000144 00000000
0020d863 00000144 00 0 00000000 00000154 00000000
00115863 00000148 00 0 00000000 0000014c 00000000
0020e863 0000014c 00 0 00000000 0000015c 00000000
00116863 00000150 00 0 00000000 00000154 00000000
00117863 00000154 00 0 00000000 00000164 00000000
0020f863 00000158 00 0 00000000 0000015c 00000000
0200066f 0000015c 0c 1 00000160 0000017c 00000000
004086e7 00000160 0d 1 00000164 00000008 00000000
34009773 00000164 0e 1 00000000 00000168 00000000
340027f3 00000168 0f 1 00000005 0000016c 00000000
34012873 0000016c 10 1 00000005 00000170 00000000
3400b8f3 00000170 11 1 fffffffd 00000174 00000000
3404d973 00000174 12 1 fffffff8 00000178 00000000
340369f3 00000178 13 1 00000009 0000017c 00000000
3401fa73 0000017c 14 1 0000000f 00000180 00000000
34002af3 00000180 15 1 0000000c 00000184 00000000
00000073 00000184 00 0 00000000 80000000 00000000
34102b73 80000000 16 1 00000184 80000004 00000000
34202bf3 80000004 17 1 0000000b 80000008 00000000
30200073 80000008 00 0 00000000 00000184 00000000
00c0ac03 00000188 00 0 00000000 0000018c 00000011
0024a423 0000018c 00 0 00000000 00000190 12345008
fe120e23 00000190 00 0 00000000 00000194 00000004
fff1cc83 00000194 00 0 00000000 00000198 00000001

// ==== list.f ====
riscv_isa_pkg.sv
alu_pkg.sv
inst_decode.sv
gpr_file.sv
csr_file.sv
alu.sv
exec_unit.sv
exec_core.sv
tb_exec_core.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - riscv_isa_pkg.sv
  - alu_pkg.sv
  - inst_decode.sv
  - gpr_file.sv
  - csr_file.sv
  - alu.sv
  - exec_unit.sv
  - exec_core.sv
  - target: test
    files:
      - tb_exec_core.sv

// ==== tb_exec_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_exec_core import riscv_isa_pkg::*; ();

  localparam logic [31:0] mtvec_reset_val = 32'h8000_0000;
  localparam int max_tests = 64;
  localparam int hold_w    = 168; // width of one whole commit record

  logic        clk;
  logic        reset;
  logic        in_valid;
  logic        in_ready;
  inst_u       inst;
  logic [31:0] pc;
  logic        commit_valid;
  logic        commit_ready;
  logic [31:0] commit_pc;
  logic [4:0]  commit_rd;
  logic        commit_wen;
  logic [31:0] commit_wdata;
  logic [31:0] commit_next_pc;
  logic [31:0] commit_mem_addr;
  logic [31:0] commit_store_data;
  logic        commit_is_load;
  logic        commit_is_store;

  inst_u       exp_inst     [max_tests];
  logic [31:0] exp_pc       [max_tests];
  logic [4:0]  exp_rd       [max_tests];
  logic        exp_wen      [max_tests];
  logic [31:0] exp_wdata    [max_tests];
  logic [31:0] exp_next_pc  [max_tests];
  logic [31:0] exp_mem_addr [max_tests]; // only meaningful for loads and stores
  logic [31:0] reg_model    [32];        // register values implied by golden write-backs

  int                n_tests;
  int                n_done;
  int                n_errors;
  int                n_failed;
  int                cycles;
  logic [31:0]       lfsr;
  logic [1:0]        ready_bits;
  logic              stalled;
  logic [hold_w-1:0] held;
  logic [hold_w-1:0] live_record;

  exec_core #(.mtvec_reset(mtvec_reset_val)) i_dut (
    .clk, .reset, .in_valid, .in_ready, .inst, .pc,
    .commit_valid, .commit_ready, .commit_pc, .commit_rd, .commit_wen, .commit_wdata,
    .commit_next_pc, .commit_mem_addr, .commit_store_data,
    .commit_is_load, .commit_is_store
  );

  assign live_record = {commit_pc, commit_rd, commit_wen, commit_wdata, commit_next_pc,
                        commit_mem_addr, commit_store_data, commit_is_load, commit_is_store};

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic load_golden();
    int          fd;
    int          code;
    string       line;
    logic [31:0] f_inst, f_pc, f_rd, f_wen, f_wdata, f_next, f_addr;
    n_tests = 0;
    fd = $fopen("exec_core_golden.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd) && (n_tests < max_tests)) begin
        code = $fgets(line, fd);
        if ((code > 0) && (line.getc(0) != "#")) begin
          code = $sscanf(line, "%h %h %h %h %h %h %h", f_inst, f_pc, f_rd, f_wen,
                         f_wdata, f_next, f_addr);
          if (code == 7) begin
            exp_inst[n_tests]     = f_inst;
            exp_pc[n_tests]       = f_pc;
            exp_rd[n_tests]       = f_rd[4:0];
            exp_wen[n_tests]      = f_wen[0];
            exp_wdata[n_tests]    = f_wdata;
            exp_next_pc[n_tests]  = f_next;
            exp_mem_addr[n_tests] = f_addr;
            n_tests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic report_mismatch(input string field, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[ERROR] %0t: %s mismatch, got %h expected %h", $time, field, got, exp);
    n_errors++;
  endtask

  task automatic check_wb(input logic [4:0] rd_got, input logic wen_got,
                          input logic [31:0] wdata_got, input logic [4:0] rd_exp,
                          input logic wen_exp, input logic [31:0] wdata_exp);
    if (wen_got !== wen_exp) report_mismatch("commit_wen", wen_got, wen_exp);
    if (wen_exp && (rd_got !== rd_exp)) report_mismatch("commit_rd", rd_got, rd_exp);
    if (wen_exp && (wdata_got !== wdata_exp)) begin
      report_mismatch("commit_wdata", wdata_got, wdata_exp);
    end
  endtask

  task automatic check_flow(input logic [31:0] pc_got, input logic [31:0] next_got,
                            input logic [31:0] pc_exp, input logic [31:0] next_exp);
    if (pc_got !== pc_exp) report_mismatch("commit_pc", pc_got, pc_exp); // order check
    if (next_got !== next_exp) report_mismatch("commit_next_pc", next_got, next_exp);
  endtask

  task automatic check_mem(input logic load_got, input logic store_got,
                           input logic [31:0] addr_got, input logic [31:0] data_got,
                           input inst_u inst_exp, input logic [31:0] addr_exp,
                           input logic [31:0] data_exp);
    logic load_exp;
    logic store_exp;
    load_exp  = (inst_exp.i_fmt.opcode == op_load);
    store_exp = (inst_exp.s_fmt.opcode == op_store);
    if (load_got !== load_exp) report_mismatch("commit_is_load", load_got, load_exp);
    if (store_got !== store_exp) report_mismatch("commit_is_store", store_got, store_exp);
    if ((load_exp || store_exp) && (addr_got !== addr_exp)) begin
      report_mismatch("commit_mem_addr", addr_got, addr_exp);
    end
    if (store_exp && (data_got !== data_exp)) begin
      report_mismatch("commit_store_data", data_got, data_exp);
    end
  endtask

  task automatic check_hold();
    if (!commit_valid) begin
      $display("[ERROR] %0t: commit_valid dropped while the commit was stalled", $time);
      n_errors++;
    end else if (live_record !== held) begin
      $display("[ERROR] %0t: commit record changed while stalled", $time);
      n_errors++;
    end
  endtask

  task automatic check_commit(input int idx);
    int          errs_before;
    inst_u       cur_inst;
    logic [31:0] data_exp;
    errs_before = n_errors;
    cur_inst    = exp_inst[idx];
    data_exp    = reg_model[cur_inst.s_fmt.rs2]; // rs2 as left by earlier instructions
    check_wb(commit_rd, commit_wen, commit_wdata, exp_rd[idx], exp_wen[idx], exp_wdata[idx]);
    check_flow(commit_pc, commit_next_pc, exp_pc[idx], exp_next_pc[idx]);
    check_mem(commit_is_load, commit_is_store, commit_mem_addr, commit_store_data,
              cur_inst, exp_mem_addr[idx], data_exp);
    if (exp_wen[idx] && (exp_rd[idx] != 5'd0)) begin
      reg_model[exp_rd[idx]] = exp_wdata[idx];
    end
    if (n_errors == errs_before) begin
      $display("test %0d pc %h inst %h ok", idx, exp_pc[idx], exp_inst[idx]);
    end else begin
      $display("test %0d pc %h inst %h mismatch", idx, exp_pc[idx], exp_inst[idx]);
      n_failed++;
    end
  endtask

  // hold valid and data until the accepting edge
  task automatic present_inst(input int idx);
    in_valid = 1'b1;
    inst     = exp_inst[idx];
    pc       = exp_pc[idx];
    do begin
      @(posedge clk);
    end while (!in_ready);
    @(negedge clk);
  endtask

  // back-pressure, low on about a quarter of cycles
  always @(negedge clk) begin
    lfsr          = lfsr_step(lfsr);
    ready_bits[0] = lfsr[0];
    lfsr          = lfsr_step(lfsr);
    ready_bits[1] = lfsr[0];
    commit_ready  = |ready_bits;
  end

  always @(posedge clk) begin
    if (reset) begin
      stalled = 1'b0;
    end else begin
      if (stalled) check_hold();
      if (commit_valid && commit_ready) begin
        if (n_done < n_tests) begin
          check_commit(n_done);
        end else begin
          $display("[ERROR] %0t: commit with no instruction outstanding", $time);
          n_errors++;
        end
        n_done++;
      end
      stalled = commit_valid && !commit_ready;
      held    = live_record;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= (n_tests * 8 + 100)) begin
      $display("timeout after %0d cycles, commits stalled at %0d of %0d",
               cycles, n_done, n_tests);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    reset        = 1'b1;
    in_valid     = 1'b0;
    inst         = '0;
    pc           = 32'b0;
    commit_ready = 1'b0;
    lfsr         = 32'h276a761d;
    n_done       = 0;
    n_errors     = 0;
    n_failed     = 0;
    cycles       = 0;
    stalled      = 1'b0;
    held         = '0;
    for (int r = 0; r < 32; r++) begin
      reg_model[r] = 32'b0;
    end
    load_golden();
    if (n_tests == 0) begin
      $display("golden file missing or holding no test lines");
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < n_tests; i++) begin
        present_inst(i);
      end
      in_valid = 1'b0;
      wait (n_done >= n_tests);
      repeat (2) @(negedge clk); // catch any stray extra commit
      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               n_tests, n_tests - n_failed, n_failed, n_errors);
      if (n_errors == 0) begin
        $display("SIMULATION PASSED");
      end else begin
        $display("SIMULATION FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== exec_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_core import riscv_isa_pkg::*, alu_pkg::*; #(
  parameter logic [31:0] mtvec_reset = 32'h8000_0000
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        in_valid,
  output logic        in_ready,
  input  inst_u       inst,
  input  logic [31:0] pc,

  output logic        commit_valid,
  input  logic        commit_ready,
  output logic [31:0] commit_pc,
  output logic [4:0]  commit_rd,
  output logic        commit_wen,
  output logic [31:0] commit_wdata,
  output logic [31:0] commit_next_pc,
  output logic [31:0] commit_mem_addr,
  output logic [31:0] commit_store_data,
  output logic        commit_is_load,
  output logic        commit_is_store
);

  logic [4:0]  gpr_raddr1, gpr_raddr2, gpr_waddr, rd;
  logic [31:0] gpr_rdata1, gpr_rdata2, gpr_wdata;
  logic        gpr_we;
  logic [11:0] csr_raddr, csr_waddr;
  logic [31:0] csr_rdata, csr_wdata, trap_pc;
  logic        csr_we, trap;
  logic [31:0] alu_a, alu_b, alu_result;
  alu_op_e     alu_funct;
  logic        alu_funcs;
  opcode_e     opcode;
  logic [2:0]  funct;
  logic [31:0] src1, src2, imm, csr;
  logic        dec_valid, dec_ready;

  inst_decode u_decode (
    .in_valid, .in_ready, .inst, .pc,
    .gpr_raddr1, .gpr_rdata1, .gpr_raddr2, .gpr_rdata2,
    .csr_raddr, .csr_rdata,
    .alu_a, .alu_b, .alu_funct, .alu_funcs,
    .opcode, .funct, .rd, .src1, .src2, .imm, .csr,
    .out_valid (dec_valid),
    .out_ready (dec_ready)
  );

  gpr_file u_gpr (
    .clk, .reset,
    .raddr1 (gpr_raddr1), .rdata1 (gpr_rdata1),
    .raddr2 (gpr_raddr2), .rdata2 (gpr_rdata2),
    .we (gpr_we), .waddr (gpr_waddr), .wdata (gpr_wdata)
  );

  csr_file #(.mtvec_reset(mtvec_reset)) u_csr (
    .clk, .reset,
    .raddr (csr_raddr), .rdata (csr_rdata),
    .we (csr_we), .waddr (csr_waddr), .wdata (csr_wdata),
    .trap, .trap_pc
  );

  alu u_alu (
    .a (alu_a), .b (alu_b), .funct (alu_funct), .funcs (alu_funcs), .result (alu_result)
  );

  exec_unit u_exec (
    .clk, .reset,
    .in_valid (dec_valid), .in_ready (dec_ready),
    .pc, .opcode, .funct, .rd, .src1, .src2, .imm, .csr, .alu_result,
    .gpr_we, .gpr_waddr, .gpr_wdata,
    .csr_we, .csr_waddr, .csr_wdata, .trap, .trap_pc,
    .commit_valid, .commit_ready, .commit_pc, .commit_rd, .commit_wen, .commit_wdata,
    .commit_next_pc, .commit_mem_addr, .commit_store_data,
    .commit_is_load, .commit_is_store
  );

endmodule

`default_nettype wire

// ==== exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_unit import riscv_isa_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        in_valid,
  output logic        in_ready,
  input  logic [31:0] pc,
  input  opcode_e     opcode,
  input  logic [2:0]  funct,
  input  logic [4:0]  rd,
  input  logic [31:0] src1,
  input  logic [31:0] src2,
  input  logic [31:0] imm,
  input  logic [31:0] csr,
  input  logic [31:0] alu_result,

  output logic        gpr_we,
  output logic [4:0]  gpr_waddr,
  output logic [31:0] gpr_wdata,
  output logic        csr_we,
  output logic [11:0] csr_waddr,
  output logic [31:0] csr_wdata,
  output logic        trap,
  output logic [31:0] trap_pc,

  output logic        commit_valid,
  input  logic        commit_ready,
  output logic [31:0] commit_pc,
  output logic [4:0]  commit_rd,
  output logic        commit_wen,
  output logic [31:0] commit_wdata,
  output logic [31:0] commit_next_pc,
  output logic [31:0] commit_mem_addr,
  output logic [31:0] commit_store_data,
  output logic        commit_is_load,
  output logic        commit_is_store
);

  logic        accept;
  logic        is_sys_priv, is_ecall, is_mret, is_csr;
  logic        taken, writes_rd;
  logic [31:0] pc_plus4, next_pc;

  assign in_ready = !commit_valid || commit_ready;
  assign accept   = in_valid && in_ready;

  assign is_sys_priv = (opcode == op_sys) && (funct == 3'b000);
  assign is_ecall    = is_sys_priv && (imm[11:0] == funct12_ecall);
  assign is_mret     = is_sys_priv && (imm[11:0] == funct12_mret);
  assign is_csr      = (opcode == op_sys) && (funct != 3'b000);

  always_comb begin
    case (funct)
      br_beq:           taken = (alu_result == 32'b0);
      br_bne:           taken = (alu_result != 32'b0);
      br_blt, br_bltu:  taken = alu_result[0];
      br_bge, br_bgeu:  taken = !alu_result[0];
      default:          taken = 1'b0;
    endcase
  end

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    next_pc = pc_plus4;
    case (opcode)
      op_jal:    next_pc = pc + imm;
      op_jalr:   next_pc = (src1 + imm) & ~32'd1;
      op_branch: next_pc = taken ? (pc + imm) : pc_plus4;
      op_sys:    next_pc = (is_ecall || is_mret) ? csr : pc_plus4; // mtvec or mepc
      default:   ;
    endcase
  end

  assign writes_rd = (opcode == op_lui) || (opcode == op_auipc) || (opcode == op_jal) ||
                     (opcode == op_jalr) || (opcode == op_calri) ||
                     (opcode == op_calrr) || is_csr;

  assign gpr_we    = accept && writes_rd;
  assign gpr_waddr = rd;
  // csr ops return the old value, jumps get pc+4 from the alu
  assign gpr_wdata = is_csr ? csr : alu_result;

  // set / clear with a zero source leave the csr unchanged, so no write
  assign csr_we    = accept && is_csr && ((funct[1:0] == 2'b01) || (alu_result != csr));
  assign csr_waddr = imm[11:0];
  assign csr_wdata = alu_result;
  assign trap      = accept && is_ecall;
  assign trap_pc   = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      commit_valid <= 1'b0;
    end else if (accept) begin
      commit_valid <= 1'b1;
    end else if (commit_ready) begin
      commit_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      commit_pc         <= pc;
      commit_rd         <= rd;
      commit_wen        <= writes_rd;
      commit_wdata      <= gpr_wdata;
      commit_next_pc    <= next_pc;
      commit_mem_addr   <= alu_result; // src1 + offset
      commit_store_data <= src2;
      commit_is_load    <= (opcode == op_load);
      commit_is_store   <= (opcode == op_store);
    end
  end

  a_commit_hold: assert property (@(posedge clk) disable iff (reset)
    (commit_valid && !commit_ready) |=> commit_valid && $stable(commit_pc) &&
      $stable(commit_rd) && $stable(commit_wen) && $stable(commit_wdata) &&
      $stable(commit_next_pc) && $stable(commit_mem_addr) &&
      $stable(commit_store_data) && $stable(commit_is_load) && $stable(commit_is_store));

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu import alu_pkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  alu_op_e     funct,
  input  logic        funcs,
  output logic [31:0] result
);

  logic [4:0]  shamt;
  logic [31:0] sra_res;

  assign shamt   = b[4:0];
  assign sra_res = $signed(a) >>> shamt; // kept apart so the shift stays signed

  always_comb begin
    case (funct)
      alu_add: result = funcs ? (a - b) : (a + b);
      alu_shl: result = a << shamt;
      alu_lts: result = {31'b0, $signed(a) < $signed(b)};
      alu_ltu: result = {31'b0, a < b};
      alu_xor: result = a ^ b;
      alu_shr: result = funcs ? sra_res : (a >> shamt);
      alu_or:  result = a | b;
      alu_and: result = funcs ? (a & ~b) : (a & b); // clear form for csrrc
      default: result = 32'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== csr_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_file import riscv_isa_pkg::*; #(
  parameter logic [31:0] mtvec_reset = 32'h0000_0100
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [11:0] raddr,
  output logic [31:0] rdata,
  input  logic        we,
  input  logic [11:0] waddr,
  input  logic [31:0] wdata,
  input  logic        trap,
  input  logic [31:0] trap_pc
);

  logic [31:0] mtvec, mepc, mcause, mscratch;

  always_comb begin
    case (raddr)
      csr_mtvec:    rdata = mtvec;
      csr_mepc:     rdata = mepc;
      csr_mcause:   rdata = mcause;
      csr_mscratch: rdata = mscratch;
      default:      rdata = 32'b0; // unimplemented
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mtvec    <= mtvec_reset;
      mepc     <= 32'b0;
      mcause   <= 32'b0;
      mscratch <= 32'b0;
    end else if (trap) begin
      mepc   <= trap_pc;
      mcause <= mcause_ecall_m; // ecall is the only trap source
    end else if (we) begin
      case (waddr)
        csr_mtvec:    mtvec    <= wdata;
        csr_mepc:     mepc     <= wdata;
        csr_mcause:   mcause   <= wdata;
        csr_mscratch: mscratch <= wdata;
        default:      ; // writes to unknown csrs dropped
      endcase
    end
  end

  // execute unit must never request a trap and a csr write on one edge
  a_trap_we_excl: assert property (@(posedge clk) disable iff (reset) !(trap && we));

endmodule

`default_nettype wire

// ==== gpr_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module gpr_file (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  raddr1,
  output logic [31:0] rdata1,
  input  logic [4:0]  raddr2,
  output logic [31:0] rdata2,
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'b0;
      end
    end else if (we && (waddr != 5'd0)) begin // x0 writes vanish
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  // holds across any sequence of writes, x0 included
  a_x0_zero: assert property (@(posedge clk) disable iff (reset)
    ((raddr1 == 5'd0) |-> (rdata1 == 32'b0)) and
    ((raddr2 == 5'd0) |-> (rdata2 == 32'b0)));

endmodule

`default_nettype wire

// ==== inst_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_decode import riscv_isa_pkg::*, alu_pkg::*; (
  input  logic        in_valid,
  output logic        in_ready,
  input  inst_u       inst,
  input  logic [31:0] pc,

  output logic [4:0]  gpr_raddr1,
  input  logic [31:0] gpr_rdata1,
  output logic [4:0]  gpr_raddr2,
  input  logic [31:0] gpr_rdata2,

  output logic [11:0] csr_raddr,
  input  logic [31:0] csr_rdata,

  output logic [31:0] alu_a,
  output logic [31:0] alu_b,
  output alu_op_e     alu_funct,
  output logic        alu_funcs,

  output opcode_e     opcode,
  output logic [2:0]  funct,
  output logic [4:0]  rd,
  output logic [31:0] src1,
  output logic [31:0] src2,
  output logic [31:0] imm,
  output logic [31:0] csr,
  output logic        out_valid,
  input  logic        out_ready
);

  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [31:0] zimm;
  logic [31:0] sys_a;
  alu_op_e     br_funct;
  alu_op_e     sys_funct;
  logic        funcs_en;

  // pure combinational stage, handshake passes through
  assign out_valid = in_valid;
  assign in_ready  = out_ready;

  assign opcode = inst.r_fmt.opcode;
  assign funct  = inst.r_fmt.funct3;
  assign rd     = inst.r_fmt.rd;

  assign gpr_raddr1 = inst.r_fmt.rs1;
  assign gpr_raddr2 = inst.r_fmt.rs2;
  assign src1       = gpr_rdata1;
  assign src2       = gpr_rdata2;

  assign imm_i = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
  assign imm_s = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
  assign imm_b = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                  inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {inst.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                  inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    case (opcode)
      op_calri, op_load, op_jalr, op_sys: imm = imm_i; // sys carries the csr number here
      op_store:                           imm = imm_s;
      op_branch:                          imm = imm_b;
      op_lui, op_auipc:                   imm = imm_u;
      op_jal:                             imm = imm_j;
      default:                            imm = 32'b0;
    endcase
  end

  // ecall fetches the trap vector, mret the return pc
  assign zimm = {27'b0, inst.r_fmt.rs1};
  assign csr_raddr = (funct != 3'b000) ? inst.i_fmt.imm_11_0 :
                     (inst.i_fmt.imm_11_0 == funct12_ecall) ? csr_mtvec : csr_mepc;
  assign csr = csr_rdata;

  always_comb begin
    case (funct)
      3'b000:            sys_a = pc; // ecall / mret, pc passes through xor 0
      csrf_rw, csrf_rwi: sys_a = 32'b0;
      default:           sys_a = csr;
    endcase
  end

  always_comb begin
    case (opcode)
      op_load, op_store, op_calri, op_calrr, op_branch: alu_a = src1;
      op_auipc, op_jal, op_jalr:                        alu_a = pc;
      op_sys:                                           alu_a = sys_a;
      default:                                          alu_a = 32'b0; // lui
    endcase
  end

  always_comb begin
    case (opcode)
      op_calrr, op_branch:                         alu_b = src2;
      op_lui, op_auipc, op_load, op_store, op_calri: alu_b = imm;
      op_sys:                                      alu_b = funct[2] ? zimm : src1;
      default:                                     alu_b = 32'd4; // link value pc+4
    endcase
  end

  always_comb begin
    case (funct)
      br_blt, br_bge:   br_funct = alu_lts;
      br_bltu, br_bgeu: br_funct = alu_ltu;
      default:          br_funct = alu_xor; // beq / bne test for zero
    endcase
  end

  always_comb begin
    case (funct)
      csrf_rs, csrf_rsi: sys_funct = alu_or;
      csrf_rc, csrf_rci: sys_funct = alu_and; // inverted b via funcs
      default:           sys_funct = alu_xor; // write forms and ecall
    endcase
  end

  always_comb begin
    case (opcode)
      op_calri, op_calrr: alu_funct = alu_op_e'(funct);
      op_branch:          alu_funct = br_funct;
      op_sys:             alu_funct = sys_funct;
      default:            alu_funct = alu_add;
    endcase
  end

  // only srai among the immediate ops uses bit 30
  assign funcs_en = (opcode == op_calrr) ||
                    ((opcode == op_calri) && (funct == 3'(alu_shr)));
  assign alu_funcs = (inst.r_fmt.funct7[5] && funcs_en) ||
                     ((opcode == op_sys) && (funct[1:0] == 2'b11));

endmodule

`default_nettype wire

// ==== alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  // same encoding as funct3 of op / op-imm, so reg ops pass funct3 straight in
  typedef enum logic [2:0] {
    alu_add = 3'b000, // sub with funcs
    alu_shl = 3'b001,
    alu_lts = 3'b010,
    alu_ltu = 3'b011,
    alu_xor = 3'b100,
    alu_shr = 3'b101, // sra with funcs
    alu_or  = 3'b110,
    alu_and = 3'b111  // and-not with funcs
  } alu_op_e;

endpackage

`default_nettype wire

// ==== riscv_isa_pkg.sv ====
`default_nettype none

package riscv_isa_pkg;

  // major opcode, inst[6:2]
  typedef enum logic [4:0] {
    op_load   = 5'b00000,
    op_calri  = 5'b00100,
    op_auipc  = 5'b00101,
    op_store  = 5'b01000,
    op_calrr  = 5'b01100,
    op_lui    = 5'b01101,
    op_branch = 5'b11000,
    op_jalr   = 5'b11001,
    op_jal    = 5'b11011,
    op_sys    = 5'b11100
  } opcode_e;

  localparam logic [2:0] br_beq  = 3'b000;
  localparam logic [2:0] br_bne  = 3'b001;
  localparam logic [2:0] br_blt  = 3'b100;
  localparam logic [2:0] br_bge  = 3'b101;
  localparam logic [2:0] br_bltu = 3'b110;
  localparam logic [2:0] br_bgeu = 3'b111;

  localparam logic [2:0] csrf_rw  = 3'b001;
  localparam logic [2:0] csrf_rs  = 3'b010;
  localparam logic [2:0] csrf_rc  = 3'b011;
  localparam logic [2:0] csrf_rwi = 3'b101; // zimm forms
  localparam logic [2:0] csrf_rsi = 3'b110;
  localparam logic [2:0] csrf_rci = 3'b111;

  // imm field of sys instructions with funct3 = 0
  localparam logic [11:0] funct12_ecall = 12'h000;
  localparam logic [11:0] funct12_mret  = 12'h302;

  localparam logic [11:0] csr_mtvec    = 12'h305;
  localparam logic [11:0] csr_mscratch = 12'h340;
  localparam logic [11:0] csr_mepc     = 12'h341;
  localparam logic [11:0] csr_mcause   = 12'h342;

  localparam logic [31:0] mcause_ecall_m = 32'd11; // environment call from m-mode

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
    logic [1:0] quad;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
    logic [1:0]  quad;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
    logic [1:0] quad;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
    logic [1:0] quad;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
    logic [1:0]  quad;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
    logic [1:0] quad;
  } j_fmt_t;

  // one instruction word, seen through each encoding format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

endpackage

`default_nettype wire
